//--- lsu_settings.svh
////////////////////////////////////////
// lsu settings: widths, axi id and sram
// depth and latency for the memory stage
////////////////////////////////////////
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

`define LSU_XLEN 32        // data width
`define LSU_ALEN 32        // byte address width

`define LSU_AXI_ID 4'h1    // same id on read and write

`define LSU_MEM_WORDS 1024 // sram depth in words
`define LSU_MEM_RD_LAT 2   // ar accept to rvalid

`endif

//--- lsu_pkg.sv
////////////////////////////////////////
// lsu package: stage records and axi4
// channel payload types
////////////////////////////////////////
`include "lsu_settings.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]   word_t;
    typedef logic [`LSU_ALEN-1:0]   addr_t;
    typedef logic [`LSU_XLEN/8-1:0] strb_t;
    typedef logic [4:0]             reg_idx_t;
    typedef logic [3:0]             axi_id_t;
    typedef logic [1:0]             axi_resp_t;

    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_load  = 2'd1,
        op_store = 2'd2
    } mem_op_t;

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_write,
        st_hold
    } lsu_state_t;

    typedef struct packed {
        addr_t      pc;
        mem_op_t    op;
        logic [2:0] funct3;
        addr_t      addr;       // execute result
        word_t      store_data;
        reg_idx_t   rd;
        logic       reg_wen;
    } ex_to_mem_t;

    typedef struct packed {
        addr_t    pc;
        word_t    result;
        reg_idx_t rd;
        logic     reg_wen;
        logic     bus_error;
    } mem_to_wb_t;

    typedef struct packed {
        addr_t      addr;
        axi_id_t    id;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ax_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        word_t     data;
        axi_resp_t resp;
        logic      last;
        axi_id_t   id;
    } axi_r_t;

    typedef struct packed {
        axi_resp_t resp;
        axi_id_t   id;
    } axi_b_t;

endpackage

//--- load_align.sv
////////////////////////////////////////
// load align: picks the addressed byte or
// halfword of a read beat and extends it
////////////////////////////////////////
`timescale 1ns/1ps

module load_align import lsu_pkg::*; (
    input  word_t      rdata,
    input  logic [1:0] offset,
    input  logic [2:0] funct3,
    output word_t      data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    always_comb begin
        case (offset)
            2'd0:    byte_sel = rdata[7:0];
            2'd1:    byte_sel = rdata[15:8];
            2'd2:    byte_sel = rdata[23:16];
            default: byte_sel = rdata[31:24];
        endcase
    end

    // halfwords are even, so offset[1] picks the lane
    assign half_sel = offset[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (funct3)
            3'b000: begin                                  // lb
                data = {{24{byte_sel[7]}}, byte_sel};
            end
            3'b001: begin                                  // lh
                data = {{16{half_sel[15]}}, half_sel};
            end
            3'b010: begin                                  // lw
                data = rdata;
            end
            3'b100: begin                                  // lbu
                data = {24'd0, byte_sel};
            end
            3'b101: begin                                  // lhu
                data = {16'd0, half_sel};
            end
            default: begin
                data = '0;
            end
        endcase
    end

endmodule

//--- store_align.sv
////////////////////////////////////////
// store align: moves store data to its
// byte lane and builds the write strobe
////////////////////////////////////////
`timescale 1ns/1ps

module store_align import lsu_pkg::*; (
    input  word_t      data,
    input  logic [2:0] funct3,
    input  logic [1:0] offset,
    output word_t      wdata,
    output strb_t      wstrb
);

    logic [4:0] shift;

    assign shift = {offset, 3'b000};        // bytes to bits
    assign wdata = data << shift;

    always_comb begin
        case (funct3)
            3'b000: begin                   // sb
                wstrb = strb_t'(4'b0001 << offset);
            end
            3'b001: begin                   // sh, shifted like sb
                wstrb = strb_t'(4'b0011 << offset);
            end
            3'b010: begin                   // sw
                wstrb = 4'b1111;
            end
            default: begin
                wstrb = '0;
            end
        endcase
    end

endmodule

//--- lsu_stage.sv
////////////////////////////////////////
// lsu stage: rv32i memory access, one
// record at a time over single-beat axi4
////////////////////////////////////////
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_stage import lsu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  ex_to_mem_t in_rec,
    input  logic       in_valid,
    output logic       in_ready,
    output mem_to_wb_t out_rec,
    output logic       out_valid,
    input  logic       out_ready,
    output axi_ax_t    ar,
    output logic       arvalid,
    input  logic       arready,
    output axi_ax_t    aw,
    output logic       awvalid,
    input  logic       awready,
    output axi_w_t     w,
    output logic       wvalid,
    input  logic       wready,
    input  axi_r_t     r,
    input  logic       rvalid,
    output logic       rready,
    input  axi_b_t     b,
    input  logic       bvalid,
    output logic       bready
);

    lsu_state_t state;
    ex_to_mem_t rec_q;
    word_t      result_q;
    logic       bus_error_q;
    word_t      load_data;
    word_t      store_wdata;
    strb_t      store_strb;
    axi_ax_t    ax_req;
    logic       accept;
    logic       r_fire;
    logic       b_fire;

    assign accept    = in_valid && in_ready;
    assign r_fire    = rvalid && rready;
    assign b_fire    = bvalid && bready;
    assign in_ready  = (state == st_idle);
    assign out_valid = (state == st_hold);
    assign rready    = (state == st_read);
    assign bready    = (state == st_write);

    always_ff @(posedge clock) begin
        if (accept) begin
            rec_q <= in_rec;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= st_idle;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        case (in_rec.op)
                            op_load: begin
                                state   <= st_read;
                                arvalid <= 1'b1;
                            end
                            op_store: begin
                                state   <= st_write;
                                awvalid <= 1'b1;
                                wvalid  <= 1'b1;
                            end
                            default: begin
                                state <= st_hold;   // pass-through
                            end
                        endcase
                    end
                end
                st_read: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                    end
                    if (r_fire) begin
                        state <= st_hold;
                    end
                end
                st_write: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (b_fire) begin
                        state <= st_hold;
                    end
                end
                default: begin
                    if (out_ready) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            result_q    <= in_rec.addr;
            bus_error_q <= 1'b0;
        end else if (r_fire) begin
            result_q    <= load_data;
            bus_error_q <= (r.resp != 2'b00);
        end else if (b_fire) begin
            result_q    <= '0;                  // stores write nothing back
            bus_error_q <= (b.resp != 2'b00);
        end
    end

    load_align i_load_align (
        .rdata  (r.data),
        .offset (rec_q.addr[1:0]),
        .funct3 (rec_q.funct3),
        .data   (load_data)
    );

    store_align i_store_align (
        .data   (rec_q.store_data),
        .funct3 (rec_q.funct3),
        .offset (rec_q.addr[1:0]),
        .wdata  (store_wdata),
        .wstrb  (store_strb)
    );

    assign ax_req = '{addr: rec_q.addr, id: `LSU_AXI_ID, len: 8'd0, size: 3'd2, burst: 2'd0};
    assign ar     = ax_req;
    assign aw     = ax_req;
    assign w      = '{data: store_wdata, strb: store_strb, last: 1'b1};

    assign out_rec = '{pc: rec_q.pc, result: result_q, rd: rec_q.rd,
                       reg_wen: rec_q.reg_wen, bus_error: bus_error_q};

    a_load_funct3: assert property (@(posedge clock) disable iff (reset)
        accept && in_rec.op == op_load
        |-> in_rec.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});

    a_store_funct3: assert property (@(posedge clock) disable iff (reset)
        accept && in_rec.op == op_store |-> in_rec.funct3 inside {3'b000, 3'b001, 3'b010});

    a_half_align: assert property (@(posedge clock) disable iff (reset)
        accept && in_rec.op inside {op_load, op_store} && in_rec.funct3[1:0] == 2'b01
        |-> !in_rec.addr[0]);

    a_word_align: assert property (@(posedge clock) disable iff (reset)
        accept && in_rec.op inside {op_load, op_store} && in_rec.funct3[1:0] == 2'b10
        |-> in_rec.addr[1:0] == 2'b00);

    // one channel direction at a time
    a_ar_aw_excl: assert property (@(posedge clock) disable iff (reset)
        !(arvalid && awvalid));

endmodule

//--- axi_sram.sv
////////////////////////////////////////
// axi sram: single-beat axi4 slave over
// a word array with byte strobes
////////////////////////////////////////
`timescale 1ns/1ps
`include "lsu_settings.svh"

module axi_sram import lsu_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  axi_ax_t ar,
    input  logic    arvalid,
    output logic    arready,
    input  axi_ax_t aw,
    input  logic    awvalid,
    output logic    awready,
    input  axi_w_t  w,
    input  logic    wvalid,
    output logic    wready,
    output axi_r_t  r,
    output logic    rvalid,
    input  logic    rready,
    output axi_b_t  b,
    output logic    bvalid,
    input  logic    bready
);

    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);

    word_t            mem [`LSU_MEM_WORDS];
    logic             rd_busy;
    logic [7:0]       rd_cnt;
    logic [IDX_W-1:0] rd_idx;
    logic             rd_err;
    axi_id_t          rd_id;
    word_t            rd_data;
    logic             aw_held;
    logic             w_held;
    logic [IDX_W-1:0] wr_idx;
    logic             wr_err;
    axi_id_t          wr_id;
    word_t            wr_data;
    strb_t            wr_strb;
    logic             wr_do;

    function automatic logic out_of_range(input addr_t a);
        return (a >> 2) >= `LSU_MEM_WORDS;
    endfunction

    assign arready = !rd_busy;
    assign awready = !aw_held;
    assign wready  = !w_held;
    assign wr_do   = aw_held && w_held && !bvalid;

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_busy <= 1'b0;
            rd_cnt  <= '0;
            rvalid  <= 1'b0;
        end else if (arvalid && arready) begin
            rd_busy <= 1'b1;
            rd_cnt  <= 8'(`LSU_MEM_RD_LAT - 1);
            rvalid  <= (`LSU_MEM_RD_LAT <= 1);
        end else if (rd_busy && !rvalid) begin
            if (rd_cnt <= 8'd1) begin
                rvalid <= 1'b1;
            end
            rd_cnt <= rd_cnt - 8'd1;            // latency countdown
        end else if (rvalid && rready) begin
            rvalid  <= 1'b0;
            rd_busy <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (arvalid && arready) begin
            rd_idx <= ar.addr[IDX_W+1:2];
            rd_err <= out_of_range(ar.addr);
            rd_id  <= ar.id;
        end
    end

    assign rd_data = rd_err ? '0 : mem[rd_idx];
    assign r = '{data: rd_data, resp: rd_err ? 2'b10 : 2'b00, last: 1'b1, id: rd_id};

    always_ff @(posedge clock) begin
        if (reset) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_held <= 1'b1;
            end
            if (wvalid && wready) begin
                w_held <= 1'b1;
            end
            if (wr_do) begin
                bvalid <= 1'b1;
            end
            if (bvalid && bready) begin
                bvalid  <= 1'b0;
                aw_held <= 1'b0;
                w_held  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (awvalid && awready) begin
            wr_idx <= aw.addr[IDX_W+1:2];
            wr_err <= out_of_range(aw.addr);
            wr_id  <= aw.id;
        end
        if (wvalid && wready) begin
            wr_data <= w.data;
            wr_strb <= w.strb;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_do && !wr_err) begin             // out of range writes dropped
            for (int i = 0; i < `LSU_XLEN / 8; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    assign b = '{resp: wr_err ? 2'b10 : 2'b00, id: wr_id};

    a_single_beat: assert property (@(posedge clock) disable iff (reset)
        !((arvalid && ar.len != 8'd0) || (awvalid && aw.len != 8'd0)));

endmodule

//--- mem_stage_top.sv
////////////////////////////////////////
// mem stage top: memory stage joined to
// its axi4 data sram
////////////////////////////////////////
`timescale 1ns/1ps

module mem_stage_top import lsu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  ex_to_mem_t in_rec,
    input  logic       in_valid,
    output logic       in_ready,
    output mem_to_wb_t out_rec,
    output logic       out_valid,
    input  logic       out_ready
);

    axi_ax_t ar;
    axi_ax_t aw;
    axi_w_t  w;
    axi_r_t  r;
    axi_b_t  b;
    logic    arvalid;
    logic    arready;
    logic    awvalid;
    logic    awready;
    logic    wvalid;
    logic    wready;
    logic    rvalid;
    logic    rready;
    logic    bvalid;
    logic    bready;

    lsu_stage i_lsu (
        .clock     (clock),
        .reset     (reset),
        .in_rec    (in_rec),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_rec   (out_rec),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .b         (b),
        .bvalid    (bvalid),
        .bready    (bready)
    );

    axi_sram i_sram (
        .clock   (clock),
        .reset   (reset),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

//--- tb_mem_stage.sv
////////////////////////////////////////
// memory stage testbench: table driven
// loads and stores with random stalls
////////////////////////////////////////
`timescale 1ns/1ps
`include "lsu_settings.svh"

module tb_mem_stage import lsu_pkg::*; ();

    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    logic       clock;
    logic       reset;
    ex_to_mem_t in_rec;
    logic       in_valid;
    logic       in_ready;
    mem_to_wb_t out_rec;
    logic       out_valid;
    logic       out_ready;
    integer     seed;
    logic       table_ready = 1'b0;

    // stimulus table, one slot per entry
    string      t_name   [$];
    mem_op_t    t_op     [$];
    logic [2:0] t_funct3 [$];
    addr_t      t_addr   [$];
    word_t      t_sdata  [$];
    word_t      t_result [$];
    logic       t_error  [$];

    mem_stage_top i_dut (
        .clock     (clock),
        .reset     (reset),
        .in_rec    (in_rec),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_rec   (out_rec),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input string field,
                               input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            report_failure($sformatf("MISMATCH %s %s: expected %h, actual %h",
                                     name, field, expected, actual));
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            report_failure(what);
        end
    endtask

    task automatic add_entry(input string name, input mem_op_t op, input logic [2:0] funct3,
                             input addr_t addr, input word_t sdata,
                             input word_t result, input logic error);
        t_name.push_back(name);
        t_op.push_back(op);
        t_funct3.push_back(funct3);
        t_addr.push_back(addr);
        t_sdata.push_back(sdata);
        t_result.push_back(result);
        t_error.push_back(error);
    endtask

    task automatic build_table();
        add_entry("pass_through",  op_none,  F3_B,  32'h1234_5670, 32'h0, 32'h1234_5670, 1'b0);
        add_entry("sw_word0",      op_store, F3_W,  32'h0000_0000, 32'h0bad_f00d, 32'h0, 1'b0);
        add_entry("sw_0x40",       op_store, F3_W,  32'h0000_0040, 32'h1234_5678, 32'h0, 1'b0);
        add_entry("lw_0x40",       op_load,  F3_W,  32'h0000_0040, 32'h0, 32'h1234_5678, 1'b0);
        add_entry("sb_0x41",       op_store, F3_B,  32'h0000_0041, 32'h5555_55ab, 32'h0, 1'b0);
        add_entry("sh_0x42",       op_store, F3_H,  32'h0000_0042, 32'h7777_cdef, 32'h0, 1'b0);
        add_entry("lw_merged",     op_load,  F3_W,  32'h0000_0040, 32'h0, 32'hcdef_ab78, 1'b0);
        add_entry("lb_0x43",       op_load,  F3_B,  32'h0000_0043, 32'h0, 32'hffff_ffcd, 1'b0);
        add_entry("lbu_0x43",      op_load,  F3_BU, 32'h0000_0043, 32'h0, 32'h0000_00cd, 1'b0);
        add_entry("lh_0x42",       op_load,  F3_H,  32'h0000_0042, 32'h0, 32'hffff_cdef, 1'b0);
        add_entry("lhu_0x42",      op_load,  F3_HU, 32'h0000_0042, 32'h0, 32'h0000_cdef, 1'b0);
        add_entry("lb_0x41",       op_load,  F3_B,  32'h0000_0041, 32'h0, 32'hffff_ffab, 1'b0);
        add_entry("lb_0x42",       op_load,  F3_B,  32'h0000_0042, 32'h0, 32'hffff_ffef, 1'b0);
        add_entry("lbu_0x40",      op_load,  F3_BU, 32'h0000_0040, 32'h0, 32'h0000_0078, 1'b0);
        add_entry("lh_0x40",       op_load,  F3_H,  32'h0000_0040, 32'h0, 32'hffff_ab78, 1'b0);
        add_entry("sw_oob",        op_store, F3_W,  32'h0000_1000, 32'hdead_beef, 32'h0, 1'b1);
        add_entry("lw_oob",        op_load,  F3_W,  32'h0000_1000, 32'h0, 32'h0, 1'b1);
        add_entry("lw_word0_kept", op_load,  F3_W,  32'h0000_0000, 32'h0, 32'h0bad_f00d, 1'b0);
        add_entry("lw_0x40_kept",  op_load,  F3_W,  32'h0000_0040, 32'h0, 32'hcdef_ab78, 1'b0);
        add_entry("pass_last",     op_none,  F3_W,  32'hffff_fffc, 32'h0, 32'hffff_fffc, 1'b0);
    endtask

    // called 1 ns after a rising edge, returns the same way
    task automatic run_entry(input int idx);
        ex_to_mem_t  rec;
        logic        accepted;
        logic        taken;
        logic [31:0] rnd;
        int          waited;
        rec.pc         = 32'h0000_0100 + 32'(idx) * 32'd4;
        rec.op         = t_op[idx];
        rec.funct3     = t_funct3[idx];
        rec.addr       = t_addr[idx];
        rec.store_data = t_sdata[idx];
        rec.rd         = reg_idx_t'(idx + 1);
        rec.reg_wen    = (t_op[idx] != op_store);
        in_rec   = rec;
        in_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            accepted = in_ready;            // stable until the next edge
            @(posedge clock);
            #1;
        end
        in_valid = 1'b0;
        in_rec   = '0;
        taken    = 1'b0;
        waited   = 0;
        while (!taken) begin
            rnd       = $random(seed);
            out_ready = rnd[0];
            check_true(!in_ready, "in_ready went high while a record was in flight");
            if (waited == 0 && t_op[idx] == op_none) begin
                check_true(out_valid, "pass-through result did not appear one cycle after accept");
            end
            if (out_valid && out_ready) begin
                check_value(t_name[idx], "result", t_result[idx], out_rec.result);
                check_value(t_name[idx], "bus_error", {31'd0, t_error[idx]},
                            {31'd0, out_rec.bus_error});
                check_value(t_name[idx], "pc", rec.pc, out_rec.pc);
                check_value(t_name[idx], "rd", {27'd0, rec.rd}, {27'd0, out_rec.rd});
                check_value(t_name[idx], "reg_wen", {31'd0, rec.reg_wen},
                            {31'd0, out_rec.reg_wen});
                taken = 1'b1;
            end
            waited++;
            @(posedge clock);
            #1;
        end
        out_ready = 1'b0;
        check_true(!out_valid, "a result was presented again after it was taken");
        check_true(in_ready, "stage did not return to idle after its result was taken");
    endtask

    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = t_name.size() * (`LSU_MEM_RD_LAT + 20) + 4;   // plus reset cycles
        repeat (limit) @(posedge clock);
        report_failure("timeout: the memory stage hung before all table entries completed");
    end

    initial begin
        seed      = 32'h4ff;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_rec    = '0;
        out_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        check_true(!out_valid, "out_valid high after reset");
        check_true(in_ready, "in_ready low after reset");
        check_true(!i_dut.arvalid && !i_dut.awvalid && !i_dut.wvalid,
                   "an AXI request valid was high after reset");
        check_true(!i_dut.rready && !i_dut.bready, "an AXI response ready was high after reset");
        for (int i = 0; i < t_name.size(); i++) begin
            run_entry(i);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
lsu_pkg.sv
load_align.sv
store_align.sv
lsu_stage.sv
axi_sram.sv
mem_stage_top.sv
tb_mem_stage.sv

//--- Makefile
# Verilator build and run of the memory stage testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_stage
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --assert --timing -j 0

SOURCES := lsu_settings.svh lsu_pkg.sv load_align.sv store_align.sv \
           lsu_stage.sv axi_sram.sv mem_stage_top.sv tb_mem_stage.sv

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
